/* logic/alu_params.svh */
/*
  widths and 8-bit opcode values for the two-stage integer ALU
  inverted conditional forms differ from their normal form only in bit 0
*/
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_DATA_W   64
`define ALU_FLAGS_W  6
`define ALU_OP_W     12
`define ALU_CODE_W   8

// add, sub and logic, odd code is the 32-bit form
`define OP_ADD64     8'd0
`define OP_ADD32     8'd1
`define OP_SUB64     8'd2
`define OP_SUB32     8'd3
`define OP_AND64     8'd4
`define OP_AND32     8'd5
`define OP_OR64      8'd6
`define OP_OR32      8'd7
`define OP_XOR64     8'd8
`define OP_XOR32     8'd9
`define OP_XNOR64    8'd10
`define OP_XNOR32    8'd11
`define OP_MOV64     8'd12
`define OP_MOV32     8'd13

// extensions, source is operand b
`define OP_ZXT8_64   8'd16
`define OP_ZXT16_64  8'd17
`define OP_SXT8_32   8'd18
`define OP_SXT8_64   8'd19
`define OP_SXT16_32  8'd20
`define OP_SXT16_64  8'd21
`define OP_SXT32_64  8'd22

`define OP_CMOV      8'd24
`define OP_CMOVN     8'd25
`define OP_CSET      8'd26
`define OP_CSETN     8'd27
`define OP_SAHF      8'd28
`define OP_LAHF      8'd30

`endif

/* logic/alu_pkg.sv */
/*
  opcode word, flags and condition types for the ALU
  bits 10:8 of the opcode are lanes (must be zero) or a condition, by opcode
*/
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

  typedef struct packed {
    logic                                 no_flags;
    logic [`ALU_OP_W-`ALU_CODE_W-2:0]     lanes;
    logic [`ALU_CODE_W-1:0]               code;
  } op_fields_t;

  // same word as seen by cmov and cset
  typedef struct packed {
    logic                                 no_flags;
    logic [`ALU_OP_W-`ALU_CODE_W-2:0]     cond;
    logic [`ALU_CODE_W-2:0]               code_hi;
    logic                                 invert;
  } op_cond_t;

  typedef union packed {
    op_fields_t f;
    op_cond_t   c;
  } alu_op_u;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef enum logic [3:0] {
    COND_Z,   COND_NZ,  COND_S,   COND_NS,
    COND_UGT, COND_ULE, COND_UGE, COND_ULT,
    COND_SGT, COND_SLE, COND_SGE, COND_SLT,
    COND_O,   COND_NO,  COND_P,   COND_ALWAYS
  } cond_e;

endpackage

`default_nettype wire

/* logic/alu_op_if.sv */
/*
  registered operation, operand stage to execute
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

interface alu_op_if;
  logic                   valid;
  alu_pkg::alu_op_u       op;
  logic [`ALU_DATA_W-1:0] a;
  logic [`ALU_DATA_W-1:0] b;
  alu_pkg::flags_t        flags_in;

  modport src (
    output valid, op, a, b, flags_in
  );

  modport dst (
    input valid, op, a, b, flags_in
  );
endinterface

`default_nettype wire

/* logic/alu_res_if.sv */
/*
  raw result and carries, execute to retire
  carry and overflow are already taken at the operation's width
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

interface alu_res_if;
  logic                   valid;
  logic [`ALU_CODE_W-1:0] code;
  logic                   no_flags;
  logic [`ALU_DATA_W-1:0] result;
  logic                   carry;
  logic                   aux_carry;  // out of bit 3
  logic                   overflow;
  alu_pkg::flags_t        lahf_flags;

  modport src (
    output valid, code, no_flags, result, carry, aux_carry, overflow, lahf_flags
  );

  modport dst (
    input valid, code, no_flags, result, carry, aux_carry, overflow, lahf_flags
  );
endinterface

`default_nettype wire

/* logic/alu_operand_stage.sv */
/*
  input register taking one operation per cycle with no back-pressure
  data is held over idle cycles
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_operand_stage (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   in_valid,
  input  wire alu_pkg::alu_op_u       op,
  input  wire logic [`ALU_DATA_W-1:0] a,
  input  wire logic [`ALU_DATA_W-1:0] b,
  input  wire alu_pkg::flags_t        flags_in,
  alu_op_if.src                       o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o.valid    <= 1'b0;
      o.op       <= '0;
      o.a        <= '0;
      o.b        <= '0;
      o.flags_in <= '0;
    end else begin
      o.valid <= in_valid;
      if (in_valid) begin
        o.op       <= op;
        o.a        <= a;
        o.b        <= b;
        o.flags_in <= flags_in;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/alu_cond_eval.sv */
/*
  branch condition on a flags value
  odd code inverts the even one and code 15 is always taken
*/
`timescale 1ns/1ps
`default_nettype none

module alu_cond_eval (
  input  wire alu_pkg::flags_t flags,
  input  wire alu_pkg::cond_e  cond,
  output logic                 taken
);

  always_comb begin
    case (cond)
      alu_pkg::COND_Z:      taken = flags.z;
      alu_pkg::COND_NZ:     taken = ~flags.z;
      alu_pkg::COND_S:      taken = flags.s;
      alu_pkg::COND_NS:     taken = ~flags.s;
      alu_pkg::COND_UGT:    taken = flags.c & ~flags.z;
      alu_pkg::COND_ULE:    taken = ~flags.c | flags.z;
      alu_pkg::COND_UGE:    taken = flags.c;
      alu_pkg::COND_ULT:    taken = ~flags.c;
      alu_pkg::COND_SGT:    taken = ~flags.z & (flags.s == flags.o);
      alu_pkg::COND_SLE:    taken = flags.z | (flags.s != flags.o);
      alu_pkg::COND_SGE:    taken = flags.s == flags.o;
      alu_pkg::COND_SLT:    taken = flags.s != flags.o;
      alu_pkg::COND_O:      taken = flags.o;
      alu_pkg::COND_NO:     taken = ~flags.o;
      alu_pkg::COND_P:      taken = flags.p;
      alu_pkg::COND_ALWAYS: taken = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* logic/alu_exec.sv */
/*
  combinational datapath between the two registers
  32-bit forms clear the upper half; extensions and moves read operand b
  cmov and cset take the condition from opcode bits 10:8 and bit 0
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_exec (
  alu_op_if.dst  i,
  alu_res_if.src o
);

  localparam int HALF = `ALU_DATA_W / 2;

  logic [`ALU_CODE_W-1:0] code;
  logic                   is_sub;
  logic                   is_half;
  logic [`ALU_DATA_W-1:0] b_add;
  logic [`ALU_DATA_W:0]   sum;
  logic [HALF:0]          sum_lo;
  logic [4:0]             sum_nib;
  logic                   ovf_full;
  logic                   ovf_half;
  logic [`ALU_DATA_W-1:0] and_v;
  logic [`ALU_DATA_W-1:0] or_v;
  logic [`ALU_DATA_W-1:0] xor_v;
  alu_pkg::cond_e         cond_sel;
  logic                   taken;
  logic [`ALU_DATA_W-1:0] res;

  assign code    = i.op.f.code;
  assign is_sub  = (code == `OP_SUB64) || (code == `OP_SUB32);
  assign is_half = (code == `OP_ADD32) || (code == `OP_SUB32);

  // sub is a + ~b + 1
  assign b_add = is_sub ? ~i.b : i.b;
  assign sum   = {1'b0, i.a} + {1'b0, b_add} + {{`ALU_DATA_W{1'b0}}, is_sub};

  // separate narrow adders only for the carry outs
  assign sum_lo  = {1'b0, i.a[HALF-1:0]} + {1'b0, b_add[HALF-1:0]} + {{HALF{1'b0}}, is_sub};
  assign sum_nib = {1'b0, i.a[3:0]} + {1'b0, b_add[3:0]} + {4'b0, is_sub};

  // same operand signs, different result sign
  assign ovf_full = (i.a[`ALU_DATA_W-1] == b_add[`ALU_DATA_W-1]) &&
                    (sum[`ALU_DATA_W-1] != i.a[`ALU_DATA_W-1]);
  assign ovf_half = (i.a[HALF-1] == b_add[HALF-1]) && (sum_lo[HALF-1] != i.a[HALF-1]);

  assign and_v = i.a & i.b;
  assign or_v  = i.a | i.b;
  assign xor_v = i.a ^ i.b;

  assign cond_sel = alu_pkg::cond_e'({i.op.c.cond, i.op.c.invert});

  alu_cond_eval i_cond (
    .flags (i.flags_in),
    .cond  (cond_sel),
    .taken (taken)
  );

  always_comb begin
    case (code)
      `OP_ADD64, `OP_SUB64: res = sum[`ALU_DATA_W-1:0];
      `OP_ADD32, `OP_SUB32: res = {{HALF{1'b0}}, sum_lo[HALF-1:0]};
      `OP_AND64:            res = and_v;
      `OP_AND32:            res = {{HALF{1'b0}}, and_v[HALF-1:0]};
      `OP_OR64:             res = or_v;
      `OP_OR32:             res = {{HALF{1'b0}}, or_v[HALF-1:0]};
      `OP_XOR64:            res = xor_v;
      `OP_XOR32:            res = {{HALF{1'b0}}, xor_v[HALF-1:0]};
      `OP_XNOR64:           res = ~xor_v;
      `OP_XNOR32:           res = {{HALF{1'b0}}, ~xor_v[HALF-1:0]};
      `OP_MOV64:            res = i.b;
      `OP_MOV32:            res = {{HALF{1'b0}}, i.b[HALF-1:0]};
      `OP_ZXT8_64:          res = {56'b0, i.b[7:0]};
      `OP_ZXT16_64:         res = {48'b0, i.b[15:0]};
      `OP_SXT8_32:          res = {32'b0, {24{i.b[7]}}, i.b[7:0]};
      `OP_SXT8_64:          res = {{56{i.b[7]}}, i.b[7:0]};
      `OP_SXT16_32:         res = {32'b0, {16{i.b[15]}}, i.b[15:0]};
      `OP_SXT16_64:         res = {{48{i.b[15]}}, i.b[15:0]};
      `OP_SXT32_64:         res = {{32{i.b[31]}}, i.b[31:0]};
      `OP_CMOV, `OP_CMOVN:  res = taken ? i.b : i.a;
      `OP_CSET, `OP_CSETN:  res = {{(`ALU_DATA_W-1){1'b0}}, taken};
      `OP_SAHF:             res = {{(`ALU_DATA_W-`ALU_FLAGS_W){1'b0}}, i.flags_in};
      default:              res = '0;  // lahf writes flags only
    endcase
  end

  assign o.valid      = i.valid;
  assign o.code       = code;
  assign o.no_flags   = i.op.f.no_flags;
  assign o.result     = res;
  assign o.carry      = is_half ? sum_lo[HALF] : sum[`ALU_DATA_W];
  assign o.aux_carry  = sum_nib[4];
  assign o.overflow   = is_half ? ovf_half : ovf_full;
  assign o.lahf_flags = alu_pkg::flags_t'(i.a[`ALU_FLAGS_W-1:0]);

endmodule

`default_nettype wire

/* logic/alu_retire.sv */
/*
  output register and flag mux; P is only ever set by lahf
  flags_out is zero whenever sets_flags is low
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_retire (
  input  wire logic                    clk,
  input  wire logic                    rst,
  alu_res_if.dst                       i,
  output logic                         out_valid,
  output logic [`ALU_DATA_W-1:0]       result,
  output alu_pkg::flags_t              flags_out,
  output logic                         sets_flags
);

  localparam int HALF = `ALU_DATA_W / 2;

  logic                   valid_q;
  logic [`ALU_CODE_W-1:0] code_q;
  logic                   no_flags_q;
  logic [`ALU_DATA_W-1:0] result_q;
  logic                   carry_q;
  logic                   aux_q;
  logic                   ovf_q;
  alu_pkg::flags_t        lahf_q;
  logic                   half;
  logic                   zero;
  logic                   sign;
  logic                   writes;
  alu_pkg::flags_t        flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= 1'b0;
      code_q     <= '0;
      no_flags_q <= 1'b0;
      result_q   <= '0;
      carry_q    <= 1'b0;
      aux_q      <= 1'b0;
      ovf_q      <= 1'b0;
      lahf_q     <= '0;
    end else begin
      valid_q    <= i.valid;
      code_q     <= i.code;
      no_flags_q <= i.no_flags;
      result_q   <= i.result;
      carry_q    <= i.carry;
      aux_q      <= i.aux_carry;
      ovf_q      <= i.overflow;
      lahf_q     <= i.lahf_flags;
    end
  end

  assign half = code_q inside {`OP_ADD32, `OP_SUB32, `OP_AND32, `OP_OR32, `OP_XOR32, `OP_XNOR32};
  assign zero = half ? (result_q[HALF-1:0] == '0) : (result_q == '0);
  assign sign = half ? result_q[HALF-1] : result_q[`ALU_DATA_W-1];

  always_comb begin
    flags  = '0;
    writes = 1'b0;
    case (code_q)
      `OP_ADD64, `OP_ADD32: begin
        flags  = {carry_q, ovf_q, aux_q, sign, zero, 1'b0};
        writes = ~no_flags_q;
      end
      `OP_SUB64, `OP_SUB32: begin
        flags  = {carry_q, ovf_q, ~aux_q, sign, zero, 1'b0};  // A is inverted on sub
        writes = ~no_flags_q;
      end
      `OP_AND64, `OP_AND32, `OP_OR64, `OP_OR32,
      `OP_XOR64, `OP_XOR32, `OP_XNOR64, `OP_XNOR32: begin
        flags  = {3'b000, sign, zero, 1'b0};
        writes = ~no_flags_q;
      end
      `OP_LAHF: begin
        flags  = lahf_q;
        writes = 1'b1;  // ignores no_flags
      end
      default: ;
    endcase
  end

  assign out_valid  = valid_q;
  assign result     = result_q;
  assign sets_flags = valid_q & writes;
  assign flags_out  = sets_flags ? flags : '0;

endmodule

`default_nettype wire

/* logic/alu_top.sv */
/*
  two-stage integer ALU with the result 2 cycles after in_valid
  a new operation may enter every cycle and there is no stall input
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_top (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   in_valid,
  input  wire alu_pkg::alu_op_u       op,
  input  wire logic [`ALU_DATA_W-1:0] a,
  input  wire logic [`ALU_DATA_W-1:0] b,
  input  wire alu_pkg::flags_t        flags_in,
  output logic                        out_valid,
  output logic [`ALU_DATA_W-1:0]      result,
  output alu_pkg::flags_t             flags_out,
  output logic                        sets_flags
);

  alu_op_if  op_bus ();
  alu_res_if res_bus ();

  alu_operand_stage i_operand (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .op       (op),
    .a        (a),
    .b        (b),
    .flags_in (flags_in),
    .o        (op_bus.src)
  );

  alu_exec i_exec (
    .i (op_bus.dst),
    .o (res_bus.src)
  );

  alu_retire i_retire (
    .clk        (clk),
    .rst        (rst),
    .i          (res_bus.dst),
    .out_valid  (out_valid),
    .result     (result),
    .flags_out  (flags_out),
    .sets_flags (sets_flags)
  );

endmodule

`default_nettype wire

/* verification/alu_asserts.sv */
/*
  port checks for alu_top, sampled on clk and disabled in reset
*/
`timescale 1ns/1ps
`default_nettype none

module alu_asserts (
  input wire logic            clk,
  input wire logic            rst,
  input wire logic            in_valid,
  input wire logic            out_valid,
  input wire alu_pkg::flags_t flags_out,
  input wire logic            sets_flags
);

  int fail_count = 0;

  latency_a: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 2))
    else begin
      fail_count++;
      $error("out_valid does not follow in_valid by 2 cycles");
    end

  flags_zero_a: assert property (@(posedge clk) disable iff (rst)
    !sets_flags |-> flags_out == '0)
    else begin
      fail_count++;
      $error("flags_out nonzero while sets_flags is low");
    end

  sets_valid_a: assert property (@(posedge clk) disable iff (rst)
    sets_flags |-> out_valid)
    else begin
      fail_count++;
      $error("sets_flags high without out_valid");
    end

endmodule

`default_nettype wire

/* verification/alu_tb_model.svh */
/*
  reference model of the ALU, included inside the testbench module
  moves and extensions read b, lahf returns a zero result
*/
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

`include "alu_params.svh"

typedef struct packed {
  logic [`ALU_DATA_W-1:0] result;
  alu_pkg::flags_t        flags;
  logic                   sets;
} expect_t;

// even code is the plain test, odd code its inverse, 15 always
function automatic logic cond_taken(input alu_pkg::flags_t f, input logic [3:0] cc);
  logic t;
  case (cc[3:1])
    3'd0:    t = f.z;
    3'd1:    t = f.s;
    3'd2:    t = f.c & ~f.z;  // unsigned greater
    3'd3:    t = f.c;
    3'd4:    t = ~f.z & (f.s == f.o);
    3'd5:    t = f.s == f.o;
    3'd6:    t = f.o;
    default: t = f.p;
  endcase
  return (cc == 4'd15) ? 1'b1 : t ^ cc[0];
endfunction

function automatic expect_t alu_model(input alu_pkg::alu_op_u op,
                                      input logic [`ALU_DATA_W-1:0] a,
                                      input logic [`ALU_DATA_W-1:0] b,
                                      input alu_pkg::flags_t fin);
  expect_t                e;
  logic [`ALU_CODE_W-1:0] code;
  logic [`ALU_DATA_W-1:0] x;
  logic [`ALU_DATA_W-1:0] y;
  logic                   half;
  logic                   arith;
  logic                   logic_op;
  int                     msb;
  code     = op.f.code;
  half     = code inside {`OP_ADD32, `OP_SUB32, `OP_AND32, `OP_OR32, `OP_XOR32, `OP_XNOR32};
  arith    = code inside {`OP_ADD64, `OP_ADD32, `OP_SUB64, `OP_SUB32};
  logic_op = code inside {`OP_AND64, `OP_AND32, `OP_OR64, `OP_OR32,
                          `OP_XOR64, `OP_XOR32, `OP_XNOR64, `OP_XNOR32};
  msb      = half ? 31 : 63;
  x        = half ? {32'b0, a[31:0]} : a;
  y        = half ? {32'b0, b[31:0]} : b;
  e        = '0;
  case (code)
    `OP_ADD64, `OP_ADD32: begin
      e.result  = x + y;
      e.flags.c = half ? e.result[32] : (e.result < x);
      e.flags.o = (x[msb] == y[msb]) && (e.result[msb] != x[msb]);
      e.flags.a = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
    end
    `OP_SUB64, `OP_SUB32: begin
      e.result  = x - y;
      e.flags.c = x >= y;  // set when no borrow
      e.flags.o = (x[msb] != y[msb]) && (e.result[msb] != x[msb]);
      e.flags.a = a[3:0] < b[3:0];
    end
    `OP_AND64, `OP_AND32:   e.result = x & y;
    `OP_OR64, `OP_OR32:     e.result = x | y;
    `OP_XOR64, `OP_XOR32:   e.result = x ^ y;
    `OP_XNOR64, `OP_XNOR32: e.result = ~(x ^ y);
    `OP_MOV64:              e.result = b;
    `OP_MOV32:              e.result = {32'b0, b[31:0]};
    `OP_ZXT8_64:            e.result = 64'(b[7:0]);
    `OP_ZXT16_64:           e.result = 64'(b[15:0]);
    `OP_SXT8_32:            e.result = {32'b0, 32'($signed(b[7:0]))};
    `OP_SXT8_64:            e.result = 64'($signed(b[7:0]));
    `OP_SXT16_32:           e.result = {32'b0, 32'($signed(b[15:0]))};
    `OP_SXT16_64:           e.result = 64'($signed(b[15:0]));
    `OP_SXT32_64:           e.result = 64'($signed(b[31:0]));
    `OP_CMOV, `OP_CMOVN:    e.result = cond_taken(fin, {op.c.cond, op.c.invert}) ? b : a;
    `OP_CSET, `OP_CSETN:    e.result = 64'(cond_taken(fin, {op.c.cond, op.c.invert}));
    `OP_SAHF:               e.result = 64'(fin);
    `OP_LAHF: begin
      e.flags = a[5:0];
      e.sets  = 1'b1;
    end
    default: ;
  endcase
  if (half) e.result[63:32] = '0;
  if (arith || logic_op) begin
    e.flags.s = e.result[msb];
    e.flags.z = e.result == '0;  // upper half already clear at 32 bits
    e.sets    = ~op.f.no_flags;
  end
  if (!e.sets) e.flags = '0;
  return e;
endfunction

`endif

/* verification/alu_tb.sv */
/*
  directed and random operations driven on the falling edge
  each result is checked 2 cycles after its in_valid
  random stimulus repeats from a fixed seed
*/
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_tb;

  localparam int DRAIN_LIMIT = 50;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  alu_pkg::alu_op_u       op;
  logic [`ALU_DATA_W-1:0] a;
  logic [`ALU_DATA_W-1:0] b;
  alu_pkg::flags_t        flags_in;
  logic                   out_valid;
  logic [`ALU_DATA_W-1:0] result;
  alu_pkg::flags_t        flags_out;
  logic                   sets_flags;
  integer                 seed = 32'h232ba650;
  int                     value_errors = 0;
  int                     timing_errors = 0;
  int                     timeout_errors = 0;
  int                     edges = 0;
  logic [1:0]             valid_hist = 2'b00;  // in_valid one and two edges back

  logic [63:0] ca [6] = '{64'd0, '1, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                         64'h7fff_ffff, 64'hffff_ffff};
  logic [63:0] cb [6] = '{64'd0, 64'd1, 64'd1, 64'd1, 64'd1, 64'hffff_ffff};
  logic [7:0]  arith_ops [4] = '{`OP_ADD64, `OP_ADD32, `OP_SUB64, `OP_SUB32};
  logic [7:0]  logic_ops [8] = '{`OP_AND64, `OP_AND32, `OP_OR64, `OP_OR32,
                                `OP_XOR64, `OP_XOR32, `OP_XNOR64, `OP_XNOR32};
  logic [7:0]  move_ops [9] = '{`OP_MOV64, `OP_MOV32, `OP_ZXT8_64, `OP_ZXT16_64,
                               `OP_SXT8_32, `OP_SXT8_64, `OP_SXT16_32, `OP_SXT16_64,
                               `OP_SXT32_64};

  `include "alu_tb_model.svh"

  expect_t exp_q[$];

  alu_top i_dut (.*);

  bind alu_top alu_asserts i_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    valid_hist <= {valid_hist[0], in_valid};
    edges      <= edges + 1;
  end

  // sample outputs half a cycle after the rising edge
  always @(negedge clk) begin
    expect_t e;
    if (edges > 0 && out_valid !== valid_hist[1]) begin
      $display("[ERROR] %0t: out_valid is %b, expected %b", $time, out_valid, valid_hist[1]);
      timing_errors++;
    end
    if (edges > 0 && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("[ERROR] %0t: out_valid with no operation in flight", $time);
        value_errors++;
      end else begin
        e = exp_q.pop_front();
        if (result !== e.result || flags_out !== e.flags || sets_flags !== e.sets) begin
          $display("[ERROR] %0t: got %h flags %b sets %b, expected %h flags %b sets %b",
                   $time, result, flags_out, sets_flags, e.result, e.flags, e.sets);
          value_errors++;
        end
      end
    end
  end

  function automatic logic [63:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic issue(input logic [7:0] code, input logic [2:0] cond, input logic nf,
                       input logic [63:0] x, input logic [63:0] y, input alu_pkg::flags_t f);
    @(negedge clk);
    in_valid      = 1'b1;
    op.f.no_flags = nf;
    op.f.lanes    = cond;  // condition field for cmov and cset
    op.f.code     = code;
    a             = x;
    b             = y;
    flags_in      = f;
    exp_q.push_back(alu_model(op, x, y, f));
  endtask

  // mostly back to back with one or two idle cycles now and then
  task automatic gap();
    int n;
    n = $unsigned($random(seed)) % 5;
    if (n > 2) n = 0;
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic issue_rnd(input logic [7:0] code, input logic [2:0] cond, input logic nf);
    issue(code, cond, nf, rnd64(), rnd64(), 6'($random(seed)));
    gap();
  endtask

  initial begin
    logic [63:0] x;
    int          k;
    int          assert_errors;
    rst      = 1'b1;
    in_valid = 1'b0;
    op       = '0;
    a        = '0;
    b        = '0;
    flags_in = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);

    // corners both ways round then random ones with a few no_flags
    foreach (arith_ops[i]) begin
      foreach (ca[j]) begin
        issue(arith_ops[i], 3'd0, 1'b0, ca[j], cb[j], '0);
        issue(arith_ops[i], 3'd0, 1'b0, cb[j], ca[j], '0);
        gap();
      end
      repeat (12) issue_rnd(arith_ops[i], 3'd0, 1'b0);
      repeat (2) issue_rnd(arith_ops[i], 3'd0, 1'b1);
    end
    foreach (logic_ops[i]) begin
      x = rnd64();
      issue(logic_ops[i], 3'd0, 1'b0, x, x, '0);
      issue(logic_ops[i], 3'd0, 1'b0, x, ~x, '0);
      repeat (8) issue_rnd(logic_ops[i], 3'd0, 1'b0);
      issue_rnd(logic_ops[i], 3'd0, 1'b1);
    end
    foreach (move_ops[i]) repeat (8) issue_rnd(move_ops[i], 3'd0, 1'b0);
    for (k = 0; k < 16; k++) begin
      repeat (4) begin
        issue_rnd(k[0] ? `OP_CMOVN : `OP_CMOV, k[3:1], 1'b0);
        issue_rnd(k[0] ? `OP_CSETN : `OP_CSET, k[3:1], 1'b0);
      end
    end
    repeat (8) begin
      issue_rnd(`OP_SAHF, 3'd0, 1'b0);
      issue_rnd(`OP_LAHF, 3'd0, 1'b0);
      issue_rnd(`OP_LAHF, 3'd0, 1'b1);  // lahf writes flags anyway
    end
    repeat (32) begin
      x = rnd64();
      issue(arith_ops[$unsigned($random(seed)) % 4], 3'd0, 1'b0, x, rnd64(), '0);
    end

    @(negedge clk);
    in_valid = 1'b0;
    k = 0;
    while (exp_q.size() != 0 && k < DRAIN_LIMIT) begin
      @(negedge clk);
      k++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never came out of the DUT", exp_q.size());
      timeout_errors++;
    end
    repeat (4) @(negedge clk);  // out_valid stays low while idle
    assert_errors = i_dut.i_asserts.fail_count;
    $display("errors: %0d value, %0d valid timing, %0d timeout, %0d assertion",
             value_errors, timing_errors, timeout_errors, assert_errors);
    if (value_errors + timing_errors + timeout_errors + assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
+incdir+verification
logic/alu_pkg.sv
logic/alu_op_if.sv
logic/alu_res_if.sv
logic/alu_operand_stage.sv
logic/alu_cond_eval.sv
logic/alu_exec.sv
logic/alu_retire.sv
logic/alu_top.sv
verification/alu_asserts.sv
verification/alu_tb.sv
